// File: design/rename_cfg_pkg.sv
`default_nettype none

package rename_cfg_pkg;

  // ------------------------------------------------
  // architectural register file
  // ------------------------------------------------
  localparam int ARCH_REGS = 32;
  localparam int ARCH_W    = 5;

  // ------------------------------------------------
  // physical register ids
  // ------------------------------------------------
  // the lower 32 of the 128 ids hold the reset identity map
  localparam int RNID_W = 7;

  // one free list per lane, each preloaded with FLIST_SIZE ids
  localparam int FLIST_SIZE = 32;
  // lane d starts at FLIST_BASE + d * FLIST_SIZE
  localparam int FLIST_BASE = 32;

  // at most 3 lanes fit in the id space
  localparam int DISP_SIZE_DEF = 2;

endpackage

`default_nettype wire

// File: design/rename_types_pkg.sv
`default_nettype none

package rename_types_pkg;

  // ------------------------------------------------
  // lane entering the rename stage
  // ------------------------------------------------
  typedef struct packed {
    logic                              valid;
    logic                              rd_valid;
    logic [rename_cfg_pkg::ARCH_W-1:0] rd_regidx;
    logic                              rs1_valid;
    logic [rename_cfg_pkg::ARCH_W-1:0] rs1_regidx;
    logic                              rs2_valid;
    logic [rename_cfg_pkg::ARCH_W-1:0] rs2_regidx;
  } disp_lane_t;

  // ------------------------------------------------
  // lane leaving the rename stage
  // ------------------------------------------------
  typedef struct packed {
    logic                              valid;
    logic [rename_cfg_pkg::RNID_W-1:0] rd_rnid;
    // mapping of rd before this lane that is freed at commit
    logic [rename_cfg_pkg::RNID_W-1:0] rd_old_rnid;
    logic [rename_cfg_pkg::RNID_W-1:0] rs1_rnid;
    logic [rename_cfg_pkg::RNID_W-1:0] rs2_rnid;
  } ren_lane_t;

endpackage

`default_nettype wire

// File: design/rename_map_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rename_map_if #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE_DEF
) ();
  import rename_cfg_pkg::*;

  // source lookups with rs1 at 2*d and rs2 at 2*d+1
  logic [DISP_SIZE*2-1:0][ARCH_W-1:0] src_regidx;
  logic [DISP_SIZE*2-1:0][RNID_W-1:0] src_rnid;

  // destination index shared by the old-id read and the update
  logic [DISP_SIZE-1:0][ARCH_W-1:0]   rd_regidx;
  logic [DISP_SIZE-1:0][RNID_W-1:0]   rd_old_rnid;

  // map updates for the firing group
  logic [DISP_SIZE-1:0]               upd_valid;
  logic [DISP_SIZE-1:0][RNID_W-1:0]   upd_rnid;

  modport stage (
    output src_regidx, rd_regidx, upd_valid, upd_rnid,
    input  src_rnid, rd_old_rnid
  );

  modport tbl (
    input  src_regidx, rd_regidx, upd_valid, upd_rnid,
    output src_rnid, rd_old_rnid
  );

endinterface

`default_nettype wire

// File: design/rename_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module rename_free_list #(
  parameter int DEPTH     = rename_cfg_pkg::FLIST_SIZE,
  parameter int INIT_BASE = rename_cfg_pkg::FLIST_BASE
) (
  input  wire                              i_clk,
  input  wire                              i_reset_n,
  input  wire                              i_push,
  input  wire [rename_cfg_pkg::RNID_W-1:0] i_push_id,
  input  wire                              i_pop,
  output logic [rename_cfg_pkg::RNID_W-1:0] o_pop_id,
  output logic                             o_empty
);
  import rename_cfg_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  logic [RNID_W-1:0] r_ids [DEPTH];
  logic [PTR_W-1:0]  r_head;
  logic [PTR_W-1:0]  r_tail;
  logic [CNT_W-1:0]  r_count;

  // ------------------------------------------------
  // pointers and storage
  // ------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= CNT_W'(DEPTH);
      // list starts full with a contiguous block of ids
      for (int i = 0; i < DEPTH; i++) begin
        r_ids[i] <= RNID_W'(INIT_BASE + i);
      end
    end else begin
      if (i_push) begin
        r_ids[r_tail] <= i_push_id;
        r_tail        <= (r_tail == LAST) ? '0 : r_tail + 1'b1;
      end
      if (i_pop) begin
        r_head <= (r_head == LAST) ? '0 : r_head + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // head id is visible before the pop edge
  assign o_pop_id = r_ids[r_head];
  assign o_empty  = (r_count == '0);

endmodule

`default_nettype wire

// File: design/rename_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map_table #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE_DEF
) (
  input  wire        i_clk,
  input  wire        i_reset_n,
  rename_map_if.tbl  map
);
  import rename_cfg_pkg::*;

  // architectural index to physical id
  logic [RNID_W-1:0] r_map [ARCH_REGS];

  // ------------------------------------------------
  // updates
  // ------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      // register i lives in id i
      for (int i = 0; i < ARCH_REGS; i++) begin
        r_map[i] <= RNID_W'(i);
      end
    end else begin
      // a later lane on the same index wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (map.upd_valid[d] && (map.rd_regidx[d] != '0)) begin
          r_map[map.rd_regidx[d]] <= map.upd_rnid[d];
        end
      end
    end
  end

  // ------------------------------------------------
  // lookups
  // ------------------------------------------------
  // entry 0 is never written and keeps id 0
  always_comb begin
    for (int s = 0; s < DISP_SIZE * 2; s++) begin
      map.src_rnid[s] = r_map[map.src_regidx[s]];
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      map.rd_old_rnid[d] = r_map[map.rd_regidx[d]];
    end
  end

endmodule

`default_nettype wire

// File: design/rename_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module rename_bypass #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE_DEF
) (
  input  wire                                             i_clk,
  input  wire                                             i_reset_n,
  input  wire                                             i_fire,
  input  rename_types_pkg::disp_lane_t [DISP_SIZE-1:0]    i_lanes,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0] i_new_rnid,
  rename_map_if.stage                                     map,
  output rename_types_pkg::ren_lane_t [DISP_SIZE-1:0]     o_ren,
  output logic                                            o_ren_valid
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  // lane really takes a new id for a nonzero rd
  logic [DISP_SIZE-1:0]             w_wr;
  logic [DISP_SIZE-1:0][RNID_W-1:0] w_rs1_rnid;
  logic [DISP_SIZE-1:0][RNID_W-1:0] w_rs2_rnid;
  logic [DISP_SIZE-1:0][RNID_W-1:0] w_old_rnid;
  ren_lane_t [DISP_SIZE-1:0]        w_ren;

  // ------------------------------------------------
  // map requests
  // ------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr[d] = i_lanes[d].valid & i_lanes[d].rd_valid & (i_lanes[d].rd_regidx != '0);
      map.src_regidx[2*d]   = i_lanes[d].rs1_regidx;
      map.src_regidx[2*d+1] = i_lanes[d].rs2_regidx;
      map.rd_regidx[d]      = i_lanes[d].rd_regidx;
      map.upd_valid[d]      = i_fire & w_wr[d];
      map.upd_rnid[d]       = i_new_rnid[d];
    end
  end

  // ------------------------------------------------
  // intra-group forwarding
  // ------------------------------------------------
  // start from the map, then let each earlier writer override in order
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_rs1_rnid[d] = map.src_rnid[2*d];
      w_rs2_rnid[d] = map.src_rnid[2*d+1];
      w_old_rnid[d] = map.rd_old_rnid[d];
      for (int p = 0; p < d; p++) begin
        if (w_wr[p] && (i_lanes[p].rd_regidx == i_lanes[d].rs1_regidx)) begin
          w_rs1_rnid[d] = i_new_rnid[p];
        end
        if (w_wr[p] && (i_lanes[p].rd_regidx == i_lanes[d].rs2_regidx)) begin
          w_rs2_rnid[d] = i_new_rnid[p];
        end
        if (w_wr[p] && (i_lanes[p].rd_regidx == i_lanes[d].rd_regidx)) begin
          w_old_rnid[d] = i_new_rnid[p];
        end
      end
      w_ren[d].valid       = i_lanes[d].valid;
      // x0 always renames to id 0
      w_ren[d].rd_rnid     = (i_lanes[d].rd_regidx != '0) ? i_new_rnid[d] : '0;
      w_ren[d].rd_old_rnid = w_old_rnid[d];
      w_ren[d].rs1_rnid    = w_rs1_rnid[d];
      w_ren[d].rs2_rnid    = w_rs2_rnid[d];
    end
  end

  // ------------------------------------------------
  // output register
  // ------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ren_valid <= 1'b0;
    end else begin
      o_ren_valid <= i_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fire) begin
      o_ren <= w_ren;
    end
  end

endmodule

`default_nettype wire

// File: design/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE_DEF
) (
  input  wire                                              i_clk,
  input  wire                                              i_reset_n,
  // dispatch group
  input  wire                                              i_disp_valid,
  input  wire [DISP_SIZE-1:0]                              i_disp_lane_valid,
  input  wire [DISP_SIZE-1:0]                              i_disp_rd_valid,
  input  wire [DISP_SIZE-1:0]                              i_disp_rs1_valid,
  input  wire [DISP_SIZE-1:0]                              i_disp_rs2_valid,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::ARCH_W-1:0]  i_disp_rd_regidx,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::ARCH_W-1:0]  i_disp_rs1_regidx,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::ARCH_W-1:0]  i_disp_rs2_regidx,
  output logic                                             o_disp_ready,
  // commit recycling
  input  wire                                              i_cmt_valid,
  input  wire [DISP_SIZE-1:0]                              i_cmt_rnid_valid,
  input  wire [DISP_SIZE-1:0]                              i_cmt_dead,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::ARCH_W-1:0]  i_cmt_rd_regidx,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0]  i_cmt_rd_rnid,
  input  wire [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0]  i_cmt_old_rnid,
  // renamed group one cycle after fire
  output logic                                             o_ren_valid,
  output logic [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0] o_ren_rd_rnid,
  output logic [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0] o_ren_rd_old_rnid,
  output logic [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0] o_ren_rs1_rnid,
  output logic [DISP_SIZE-1:0][rename_cfg_pkg::RNID_W-1:0] o_ren_rs2_rnid
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic                             w_fire;
  logic [DISP_SIZE-1:0]             w_empty;
  logic [DISP_SIZE-1:0][RNID_W-1:0] w_new_rnid;
  disp_lane_t [DISP_SIZE-1:0]       w_lanes;
  ren_lane_t  [DISP_SIZE-1:0]       w_ren;

  rename_map_if #(.DISP_SIZE(DISP_SIZE)) u_map_if ();

  // every lane needs a free entry even without rd
  assign o_disp_ready = ~|w_empty;
  assign w_fire       = i_disp_valid & o_disp_ready;

  // ------------------------------------------------
  // per-lane packing and free lists
  // ------------------------------------------------
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    assign w_lanes[d] = '{
      valid:      i_disp_lane_valid[d],
      rd_valid:   i_disp_rd_valid[d],
      rd_regidx:  i_disp_rd_regidx[d],
      rs1_valid:  i_disp_rs1_valid[d],
      rs1_regidx: i_disp_rs1_regidx[d],
      rs2_valid:  i_disp_rs2_valid[d],
      rs2_regidx: i_disp_rs2_regidx[d]
    };

    // a dead instruction gives back its own id instead of the old one
    rename_free_list #(
      .DEPTH     (FLIST_SIZE),
      .INIT_BASE (FLIST_BASE + d * FLIST_SIZE)
    ) u_free_list (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (i_cmt_valid & i_cmt_rnid_valid[d] & (i_cmt_rd_regidx[d] != '0)),
      .i_push_id (i_cmt_dead[d] ? i_cmt_rd_rnid[d] : i_cmt_old_rnid[d]),
      .i_pop     (w_fire & i_disp_lane_valid[d] & i_disp_rd_valid[d] &
                  (i_disp_rd_regidx[d] != '0)),
      .o_pop_id  (w_new_rnid[d]),
      .o_empty   (w_empty[d])
    );

    assign o_ren_rd_rnid[d]     = w_ren[d].rd_rnid;
    assign o_ren_rd_old_rnid[d] = w_ren[d].rd_old_rnid;
    assign o_ren_rs1_rnid[d]    = w_ren[d].rs1_rnid;
    assign o_ren_rs2_rnid[d]    = w_ren[d].rs2_rnid;
  end

  // ------------------------------------------------
  // map and forwarding
  // ------------------------------------------------
  rename_map_table #(.DISP_SIZE(DISP_SIZE)) u_map_table (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .map       (u_map_if)
  );

  rename_bypass #(.DISP_SIZE(DISP_SIZE)) u_bypass (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_fire      (w_fire),
    .i_lanes     (w_lanes),
    .i_new_rnid  (w_new_rnid),
    .map         (u_map_if),
    .o_ren       (w_ren),
    .o_ren_valid (o_ren_valid)
  );

endmodule

`default_nettype wire

// File: dv/rename_tb_table.svh
`ifndef RENAME_TB_TABLE_SVH
`define RENAME_TB_TABLE_SVH

// ------------------------------------------------
// stimulus table
// ------------------------------------------------
// each row holds disp valid, lane 0 rd rs1 rs2, lane 1 rd rs1 rs2, the commit word,
// the expected ready, then expected valid and lane ids one cycle later
task automatic build_table();
  logic [6:0] prev;
  add_entry(0, 0, 0, 0, 0, 0, 0, NO_CMT, 1, 0, '0, '0);
  // old ids of first writes are the register index
  add_entry(1, 1, 2, 3, 2, 4, 5, NO_CMT, 1, 1,
            lane_ids(32, 1, 2, 3), lane_ids(64, 2, 4, 5));
  // lane 1 reads and rewrites lane 0's rd
  add_entry(1, 3, 1, 2, 3, 3, 3, NO_CMT, 1, 1,
            lane_ids(33, 3, 32, 64), lane_ids(65, 33, 33, 33));
  // x0 destination pops nothing and x3 holds lane 1's id
  add_entry(1, 0, 3, 0, 4, 1, 2, NO_CMT, 1, 1,
            lane_ids(0, 0, 65, 0), lane_ids(66, 4, 32, 64));
  add_entry(1, 5, 4, 3, 0, 5, 0, NO_CMT, 1, 1,
            lane_ids(34, 5, 66, 65), lane_ids(0, 0, 34, 0));
  add_entry(0, 0, 0, 0, 0, 0, 0, NO_CMT, 1, 0, '0, '0);
  // drain lane 0 through x6 with ids 35 up to 63
  for (int k = 0; k < 29; k++) begin
    prev = (k == 0) ? 7'd6 : 7'(34 + k);
    add_entry(1, 6, 6, 0, 0, 6, 6, NO_CMT, 1, 1,
              lane_ids(7'(35 + k), prev, prev, 0), lane_ids(0, 0, 7'(35 + k), 7'(35 + k)));
  end
  // the old id of x1 comes back to the empty list
  add_entry(1, 7, 6, 0, 0, 7, 7, cmt_word(0, 1, 32, 1), 0, 0, '0, '0);
  add_entry(1, 7, 6, 0, 0, 7, 7, NO_CMT, 1, 1,
            lane_ids(1, 7, 63, 0), lane_ids(0, 0, 1, 1));
  // dead commit returns its own id
  add_entry(1, 8, 7, 6, 0, 8, 0, cmt_word(1, 3, 33, 3), 0, 0, '0, '0);
  add_entry(1, 8, 7, 6, 0, 8, 0, NO_CMT, 1, 1,
            lane_ids(33, 8, 1, 63), lane_ids(0, 0, 33, 0));
  add_entry(0, 0, 0, 0, 0, 0, 0, NO_CMT, 0, 0, '0, '0);
endtask

`endif

// File: dv/tb_rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_stage;
  import rename_cfg_pkg::*;

  // expected ids per lane are {rd, old, rs1, rs2}
  typedef struct {
    logic                   dv;
    logic [1:0][ARCH_W-1:0] rd, rs1, rs2;
    logic [20:0]            cmt;
    logic                   exp_ready, exp_valid;
    logic [1:0][27:0]       exp_ids;
  } step_t;

  localparam logic [20:0] NO_CMT = '0;

  logic i_clk, i_reset_n, i_disp_valid, i_cmt_valid, o_disp_ready, o_ren_valid;
  logic [1:0] i_disp_lane_valid, i_disp_rd_valid, i_disp_rs1_valid, i_disp_rs2_valid;
  logic [1:0] i_cmt_rnid_valid, i_cmt_dead;
  logic [1:0][ARCH_W-1:0] i_disp_rd_regidx, i_disp_rs1_regidx, i_disp_rs2_regidx;
  logic [1:0][ARCH_W-1:0] i_cmt_rd_regidx;
  logic [1:0][RNID_W-1:0] i_cmt_rd_rnid, i_cmt_old_rnid, o_ren_rd_rnid, o_ren_rd_old_rnid;
  logic [1:0][RNID_W-1:0] o_ren_rs1_rnid, o_ren_rs2_rnid;

  step_t steps[$];
  int    n_checks;
  int    n_errors;
  int    cycles;

  rename_stage #(.DISP_SIZE(2)) dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    n_checks++;
    if (exp !== got) begin
      n_errors++;
      $display("[FAIL] %s exp=%h got=%h", name, exp, got);
    end
  endtask

  function automatic logic [27:0] lane_ids(input logic [6:0] rd, old, rs1, rs2);
    return {rd, old, rs1, rs2};
  endfunction

  // commit on lane 0 only
  function automatic logic [20:0] cmt_word(input logic dead, input logic [4:0] rd,
                                           input logic [6:0] rd_rnid, old_rnid);
    return {1'b1, dead, rd, rd_rnid, old_rnid};
  endfunction

  task automatic add_entry(input logic dv, input logic [4:0] rd0, a0, b0, rd1, a1, b1,
                           input logic [20:0] cmt, input logic rdy, vld,
                           input logic [27:0] ids0, ids1);
    step_t s;
    s.dv        = dv;
    s.rd        = {rd1, rd0};
    s.rs1       = {a1, a0};
    s.rs2       = {b1, b0};
    s.cmt       = cmt;
    s.exp_ready = rdy;
    s.exp_valid = vld;
    s.exp_ids   = {ids1, ids0};
    steps.push_back(s);
  endtask

  task automatic apply_step(input step_t s);
    i_disp_valid      = s.dv;
    i_disp_lane_valid = {2{s.dv}};
    i_disp_rd_valid   = {2{s.dv}};
    i_disp_rs1_valid  = {2{s.dv}};
    i_disp_rs2_valid  = {2{s.dv}};
    i_disp_rd_regidx  = s.rd;
    i_disp_rs1_regidx = s.rs1;
    i_disp_rs2_regidx = s.rs2;
    i_cmt_valid       = s.cmt[20];
    i_cmt_rnid_valid  = {1'b0, s.cmt[20]};
    i_cmt_dead        = {1'b0, s.cmt[19]};
    i_cmt_rd_regidx   = {5'd0, s.cmt[18:14]};
    i_cmt_rd_rnid     = {7'd0, s.cmt[13:7]};
    i_cmt_old_rnid    = {7'd0, s.cmt[6:0]};
  endtask

  // ids are only meaningful when the group is valid
  task automatic check_ren(input step_t s);
    compare("o_ren_valid", 32'(s.exp_valid), 32'(o_ren_valid));
    if (s.exp_valid) begin
      for (int d = 0; d < 2; d++) begin
        logic [27:0] e;
        e = s.exp_ids[d];
        compare($sformatf("o_ren_rd_rnid[%0d]", d), 32'(e[27:21]), 32'(o_ren_rd_rnid[d]));
        compare($sformatf("o_ren_rd_old_rnid[%0d]", d), 32'(e[20:14]),
                32'(o_ren_rd_old_rnid[d]));
        compare($sformatf("o_ren_rs1_rnid[%0d]", d), 32'(e[13:7]), 32'(o_ren_rs1_rnid[d]));
        compare($sformatf("o_ren_rs2_rnid[%0d]", d), 32'(e[6:0]), 32'(o_ren_rs2_rnid[d]));
      end
    end
  endtask

`include "rename_tb_table.svh"

  // ------------------------------------------------
  // watchdog
  // ------------------------------------------------
  initial begin
    cycles = 0;
    @(posedge i_clk);
    while (cycles < 2 * steps.size() + 20) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the stimulus table did not finish", cycles);
    $display("Checks failed");
    $finish;
  end

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    n_checks  = 0;
    n_errors  = 0;
    build_table();
    i_reset_n = 1'b0;
    apply_step(steps[0]);
    repeat (3) @(posedge i_clk);
    #1 i_reset_n = 1'b1;
    // drive just after the edge and sample mid-cycle
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge i_clk);
      #1 apply_step(steps[i]);
      #48;
      compare("o_disp_ready", 32'(steps[i].exp_ready), 32'(o_disp_ready));
      if (i == 0) begin
        compare("o_ren_valid", 32'd0, 32'(o_ren_valid));
      end else begin
        check_ren(steps[i - 1]);
      end
    end
    @(posedge i_clk);
    #49 check_ren(steps[steps.size() - 1]);
    $display("checks=%0d errors=%0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
design/rename_cfg_pkg.sv
design/rename_types_pkg.sv
design/rename_map_if.sv
design/rename_free_list.sv
design/rename_map_table.sv
design/rename_bypass.sv
design/rename_stage.sv
dv/tb_rename_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_rename_stage -f all.f
./obj_dir/Vtb_rename_stage > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
